// ==== logic/axi_mem_pkg.sv ====
// ==============================
// Shared AXI memory model definitions.
// Bus widths, storage geometry, burst codes,
// response code and the fill pattern.
// ==============================

package axi_mem_pkg;

  // ==============================
  // Bus widths
  // ==============================

  localparam int axi_id_width   = 4;
  localparam int axi_addr_width = 16;
  localparam int axi_data_width = 32;
  localparam int axi_len_width  = 8;  // Holds beats minus one.
  localparam int axi_strb_width = axi_data_width / 8;

  // ==============================
  // Storage geometry
  // ==============================

  localparam int byte_off_bits = $clog2(axi_strb_width);
  localparam int mem_els       = 256;
  localparam int mem_idx_width = $clog2(mem_els);

  // Bytes that were never written read back from this word.
  localparam logic [axi_data_width-1:0] init_data = 32'hdead_beef;

  // ==============================
  // Protocol codes
  // ==============================

  typedef enum logic [1:0] {
    FIXED = 2'd0,
    INCR  = 2'd1,
    WRAP  = 2'd2
  } axi_burst_e;

  localparam logic [1:0] axi_resp_okay = 2'b00;

endpackage

// ==== logic/axi_burst_addr.sv ====
// ==============================
// Beat counter and burst address generator.
// Handles FIXED, INCR and WRAP bursts of full-width beats.
// ==============================

module axi_burst_addr (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   load_i,
  input  logic [axi_mem_pkg::axi_addr_width-1:0] base_addr_i,
  input  logic [axi_mem_pkg::axi_len_width-1:0]  len_i,
  input  axi_mem_pkg::axi_burst_e                burst_i,
  input  logic                                   step_i,
  output logic [axi_mem_pkg::axi_addr_width-1:0] addr_o,
  output logic                                   last_o
);

  import axi_mem_pkg::*;

  logic [axi_addr_width-1:0] base_r;
  logic [axi_len_width-1:0]  len_r;
  axi_burst_e                burst_r;
  logic [axi_len_width-1:0]  beat_r;

  logic [axi_addr_width-1:0] beat_off;
  logic [axi_addr_width-1:0] len_ext;
  logic [axi_addr_width-1:0] wrap_mask;
  logic [axi_addr_width-1:0] incr_addr;
  logic [axi_addr_width-1:0] wrap_addr;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      len_r   <= '0;
      burst_r <= FIXED;
      beat_r  <= '0;
    end else if (load_i) begin
      len_r   <= len_i;
      burst_r <= burst_i;
      beat_r  <= '0;
    end else if (step_i) begin
      beat_r  <= beat_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      base_r <= base_addr_i;
    end
  end

  assign len_ext   = {{(axi_addr_width-axi_len_width){1'b0}}, len_r};
  assign beat_off  = {{(axi_addr_width-axi_len_width){1'b0}}, beat_r} << byte_off_bits;
  assign wrap_mask = ((len_ext + 1'b1) << byte_off_bits) - 1'b1; // Burst size is a power of two.
  assign incr_addr = base_r + beat_off;
  assign wrap_addr = (base_r & ~wrap_mask) | (incr_addr & wrap_mask);

  always_comb begin
    case (burst_r)
      INCR:    addr_o = incr_addr;
      WRAP:    addr_o = wrap_addr;
      default: addr_o = base_r; // FIXED and the reserved code stay put.
    endcase
  end

  assign last_o = (beat_r == len_r);

  // WRAP bursts carry 2, 4, 8 or 16 beats.
  wrap_len_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    (load_i && burst_i == WRAP) |-> (len_i inside {8'd1, 8'd3, 8'd7, 8'd15}));

endmodule

// ==== logic/axi_mem_write_fsm.sv ====
// ==============================
// Write channel FSM of the AXI memory model.
// Accepts one AW address, takes the W beats of the burst,
// then returns an OKAY response on B.
// ==============================

module axi_mem_write_fsm (
  input  logic                                 clk_i,
  input  logic                                 reset_i,

  input  logic [axi_mem_pkg::axi_id_width-1:0] awid_i,
  input  logic                                 awvalid_i,
  output logic                                 awready_o,

  input  logic                                 wvalid_i,
  input  logic                                 wlast_i,
  output logic                                 wready_o,

  output logic [axi_mem_pkg::axi_id_width-1:0] bid_o,
  output logic [1:0]                           bresp_o,
  output logic                                 bvalid_o,
  input  logic                                 bready_i,

  input  logic                                 last_i,
  output logic                                 load_o,
  output logic                                 step_o
);

  import axi_mem_pkg::*;

  typedef enum logic [1:0] {
    WR_RESET,
    WR_WAIT_ADDR,
    WR_WAIT_DATA,
    WR_RESP
  } wr_state_e;

  wr_state_e                 state_r;
  wr_state_e                 state_n;
  logic [axi_id_width-1:0]   awid_r;

  // ==============================
  // Channel handshakes
  // ==============================

  assign awready_o = (state_r == WR_WAIT_ADDR);
  assign wready_o  = (state_r == WR_WAIT_DATA);
  assign bvalid_o  = (state_r == WR_RESP);

  assign load_o = awvalid_i & awready_o; // Address counter captures AW.
  assign step_o = wvalid_i & wready_o;   // One beat is written.

  assign bid_o   = awid_r;
  assign bresp_o = axi_resp_okay;

  // ==============================
  // State transitions
  // ==============================

  always_comb begin
    state_n = state_r;
    case (state_r)
      WR_RESET: begin
        state_n = WR_WAIT_ADDR;
      end
      WR_WAIT_ADDR: begin
        if (load_o) begin
          state_n = WR_WAIT_DATA;
        end
      end
      WR_WAIT_DATA: begin
        if (step_o && last_i) begin
          state_n = WR_RESP;
        end
      end
      WR_RESP: begin
        if (bready_i) begin
          state_n = WR_WAIT_ADDR;
        end
      end
      default: begin
        state_n = WR_RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= WR_RESET;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_o) begin
      awid_r <= awid_i;
    end
  end

  // The master's WLAST must agree with the beat count of the address counter.
  wlast_matches_len: assert property (@(posedge clk_i) disable iff (reset_i)
    step_o |-> (wlast_i == last_i));

endmodule

// ==== logic/axi_mem_read_fsm.sv ====
// ==============================
// Read channel FSM of the AXI memory model.
// Accepts one AR address and sends the R beats,
// flagging the final one with RLAST.
// ==============================

module axi_mem_read_fsm (
  input  logic                                 clk_i,
  input  logic                                 reset_i,

  input  logic [axi_mem_pkg::axi_id_width-1:0] arid_i,
  input  logic                                 arvalid_i,
  output logic                                 arready_o,

  output logic [axi_mem_pkg::axi_id_width-1:0] rid_o,
  output logic [1:0]                           rresp_o,
  output logic                                 rlast_o,
  output logic                                 rvalid_o,
  input  logic                                 rready_i,

  input  logic                                 last_i,
  output logic                                 load_o,
  output logic                                 step_o
);

  import axi_mem_pkg::*;

  typedef enum logic [1:0] {
    RD_RESET,
    RD_WAIT_ADDR,
    RD_SEND_DATA
  } rd_state_e;

  rd_state_e               state_r;
  rd_state_e               state_n;
  logic [axi_id_width-1:0] arid_r;

  // ==============================
  // Channel handshakes
  // ==============================

  assign arready_o = (state_r == RD_WAIT_ADDR);
  assign rvalid_o  = (state_r == RD_SEND_DATA);
  assign rlast_o   = rvalid_o & last_i;

  assign load_o = arvalid_i & arready_o;
  assign step_o = rvalid_o & rready_i; // Counter moves on each R transfer.

  assign rid_o   = arid_r;
  assign rresp_o = axi_resp_okay;

  always_comb begin
    state_n = state_r;
    case (state_r)
      RD_RESET: begin
        state_n = RD_WAIT_ADDR;
      end
      RD_WAIT_ADDR: begin
        if (load_o) begin
          state_n = RD_SEND_DATA;
        end
      end
      RD_SEND_DATA: begin
        if (step_o && last_i) begin
          state_n = RD_WAIT_ADDR;
        end
      end
      default: begin
        state_n = RD_RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= RD_RESET;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_o) begin
      arid_r <= arid_i;
    end
  end

  // A beat once offered is neither withdrawn nor changed before the master takes it.
  rvalid_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (rvalid_o && !rready_i) |=> (rvalid_o && $stable(rlast_o)));

endmodule

// ==== logic/axi_mem_array.sv ====
// ==============================
// Byte-strobed word storage.
// Per-byte written flags select between stored
// data and the fill pattern on reads.
// ==============================

module axi_mem_array (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   wr_en_i,
  input  logic [axi_mem_pkg::mem_idx_width-1:0]  wr_idx_i,
  input  logic [axi_mem_pkg::axi_data_width-1:0] wr_data_i,
  input  logic [axi_mem_pkg::axi_strb_width-1:0] wr_strb_i,
  input  logic [axi_mem_pkg::mem_idx_width-1:0]  rd_idx_i,
  output logic [axi_mem_pkg::axi_data_width-1:0] rd_data_o
);

  import axi_mem_pkg::*;

  logic [axi_data_width-1:0] mem_r     [mem_els];
  logic [axi_strb_width-1:0] written_r [mem_els];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      for (int b = 0; b < axi_strb_width; b++) begin
        if (wr_strb_i[b]) begin
          mem_r[wr_idx_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < mem_els; i++) begin
        written_r[i] <= '0;
      end
    end else if (wr_en_i) begin
      written_r[wr_idx_i] <= written_r[wr_idx_i] | wr_strb_i; // Flags only ever set.
    end
  end

  // Read is combinational, so a same-cycle write is not yet visible.
  for (genvar b = 0; b < axi_strb_width; b++) begin : g_rd_byte
    assign rd_data_o[b*8 +: 8] = written_r[rd_idx_i][b]
                               ? mem_r[rd_idx_i][b*8 +: 8]
                               : init_data[b*8 +: 8];
  end

endmodule

// ==== logic/axi_mem_top.sv ====
// ==============================
// AXI slave memory model top level.
// Write FSM, read FSM, one burst counter per path
// and the shared storage array.
// ==============================

module axi_mem_top (
  input  logic                                   clk_i,
  input  logic                                   reset_i,

  input  logic [axi_mem_pkg::axi_id_width-1:0]   awid_i,
  input  logic [axi_mem_pkg::axi_addr_width-1:0] awaddr_i,
  input  logic [axi_mem_pkg::axi_len_width-1:0]  awlen_i,
  input  axi_mem_pkg::axi_burst_e                awburst_i,
  input  logic                                   awvalid_i,
  output logic                                   awready_o,

  input  logic [axi_mem_pkg::axi_data_width-1:0] wdata_i,
  input  logic [axi_mem_pkg::axi_strb_width-1:0] wstrb_i,
  input  logic                                   wlast_i,
  input  logic                                   wvalid_i,
  output logic                                   wready_o,

  output logic [axi_mem_pkg::axi_id_width-1:0]   bid_o,
  output logic [1:0]                             bresp_o,
  output logic                                   bvalid_o,
  input  logic                                   bready_i,

  input  logic [axi_mem_pkg::axi_id_width-1:0]   arid_i,
  input  logic [axi_mem_pkg::axi_addr_width-1:0] araddr_i,
  input  logic [axi_mem_pkg::axi_len_width-1:0]  arlen_i,
  input  axi_mem_pkg::axi_burst_e                arburst_i,
  input  logic                                   arvalid_i,
  output logic                                   arready_o,

  output logic [axi_mem_pkg::axi_id_width-1:0]   rid_o,
  output logic [axi_mem_pkg::axi_data_width-1:0] rdata_o,
  output logic [1:0]                             rresp_o,
  output logic                                   rlast_o,
  output logic                                   rvalid_o,
  input  logic                                   rready_i
);

  import axi_mem_pkg::*;

  logic                      wr_load;
  logic                      wr_step;
  logic                      wr_last;
  logic [axi_addr_width-1:0] wr_addr;
  logic [mem_idx_width-1:0]  wr_idx;

  logic                      rd_load;
  logic                      rd_step;
  logic                      rd_last;
  logic [axi_addr_width-1:0] rd_addr;
  logic [mem_idx_width-1:0]  rd_idx;

  // Word index drops the byte offset, so the array aliases every 1 KB.
  assign wr_idx = wr_addr[byte_off_bits +: mem_idx_width];
  assign rd_idx = rd_addr[byte_off_bits +: mem_idx_width];

  // ==============================
  // Write path
  // ==============================

  axi_mem_write_fsm u_wr_fsm (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .awid_i    (awid_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wvalid_i  (wvalid_i),
    .wlast_i   (wlast_i),
    .wready_o  (wready_o),
    .bid_o     (bid_o),
    .bresp_o   (bresp_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .last_i    (wr_last),
    .load_o    (wr_load),
    .step_o    (wr_step)
  );

  axi_burst_addr u_wr_addr (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .load_i      (wr_load),
    .base_addr_i (awaddr_i),
    .len_i       (awlen_i),
    .burst_i     (awburst_i),
    .step_i      (wr_step),
    .addr_o      (wr_addr),
    .last_o      (wr_last)
  );

  // ==============================
  // Read path
  // ==============================

  axi_mem_read_fsm u_rd_fsm (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .arid_i    (arid_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .rid_o     (rid_o),
    .rresp_o   (rresp_o),
    .rlast_o   (rlast_o),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .last_i    (rd_last),
    .load_o    (rd_load),
    .step_o    (rd_step)
  );

  axi_burst_addr u_rd_addr (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .load_i      (rd_load),
    .base_addr_i (araddr_i),
    .len_i       (arlen_i),
    .burst_i     (arburst_i),
    .step_i      (rd_step),
    .addr_o      (rd_addr),
    .last_o      (rd_last)
  );

  axi_mem_array u_array (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wr_en_i   (wr_step),
    .wr_idx_i  (wr_idx),
    .wr_data_i (wdata_i),
    .wr_strb_i (wstrb_i),
    .rd_idx_i  (rd_idx),
    .rd_data_o (rdata_o)
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
// ==============================
// Testbench clock and reset source.
// 40 unit period, reset held for 10 cycles.
// ==============================

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  localparam int half_period  = 20;
  localparam int reset_cycles = 10;

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles) @(posedge clk_o);
    @(negedge clk_o);
    reset_o <= 1'b0; // Released on a falling edge like every other input.
  end

endmodule

// ==== tb/axi_mem_tb.sv ====
// ==============================
// Testbench for the AXI slave memory model.
// Random write and read bursts with random gaps,
// a byte-wide reference memory with written flags,
// and a cycle limit on the whole run.
// ==============================

module axi_mem_tb;

  import axi_mem_pkg::*;

  localparam int          num_txns       = 300;
  localparam int          timeout_cycles = 25000;
  localparam int          mem_bytes      = 1024; // Storage aliases every 1 KB.
  localparam logic [31:0] fill_word      = 32'hdead_beef;
  localparam logic [1:0]  okay_resp      = 2'b00;

  logic        clk;
  logic        reset;
  logic [3:0]  awid, bid, arid, rid;
  logic [15:0] awaddr, araddr;
  logic [7:0]  awlen, arlen;
  axi_burst_e  awburst, arburst;
  logic        awvalid, awready, wlast, wvalid, wready;
  logic [31:0] wdata, rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;
  logic        bvalid, bready, arvalid, arready, rlast, rvalid, rready;

  logic [7:0]  model_data    [mem_bytes];
  logic        model_written [mem_bytes];
  int unsigned cycle_count = 0;

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  axi_mem_top u_dut (
    .clk_i (clk), .reset_i (reset),
    .awid_i (awid), .awaddr_i (awaddr), .awlen_i (awlen), .awburst_i (awburst),
    .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wstrb_i (wstrb), .wlast_i (wlast), .wvalid_i (wvalid),
    .wready_o (wready),
    .bid_o (bid), .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
    .arid_i (arid), .araddr_i (araddr), .arlen_i (arlen), .arburst_i (arburst),
    .arvalid_i (arvalid), .arready_o (arready),
    .rid_o (rid), .rdata_o (rdata), .rresp_o (rresp), .rlast_o (rlast),
    .rvalid_o (rvalid), .rready_i (rready)
  );

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles.", timeout_cycles);
      $display("Something failed");
      $fatal(1, "Run stopped by the cycle limit.");
    end
  end

  // ==============================
  // Checks and reference model
  // ==============================

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
      $display("Something failed");
      $fatal(1, "Run stopped at the first error.");
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Error: %s", what);
      $display("Something failed");
      $fatal(1, "Run stopped at the first error.");
    end
  endtask

  // Address of beat n, straight from the burst rules.
  function automatic logic [15:0] beat_addr(input logic [15:0] base, input logic [7:0] len,
                                            input axi_burst_e burst, input int n);
    int b;
    int size;
    int lower;
    b     = base;
    size  = (len + 1) * 4;
    lower = b - (b % size);
    case (burst)
      INCR:    return 16'(b + n * 4);
      WRAP:    return 16'(lower + ((b - lower + n * 4) % size));
      default: return base;
    endcase
  endfunction

  function automatic int byte_index(input logic [15:0] addr, input int b);
    return int'(addr[9:2]) * 4 + b;
  endfunction

  function automatic logic [31:0] expected_word(input logic [15:0] addr);
    logic [31:0] word;
    int          a;
    for (int b = 0; b < 4; b++) begin
      a = byte_index(addr, b);
      word[b*8 +: 8] = model_written[a] ? model_data[a] : fill_word[b*8 +: 8];
    end
    return word;
  endfunction

  task automatic idle_gap();
    repeat ($urandom % 4) @(negedge clk);
  endtask

  // ==============================
  // Bursts
  // ==============================

  task automatic do_write(input logic [3:0] id, input logic [15:0] base,
                          input logic [7:0] len, input axi_burst_e burst);
    logic [15:0] addr;
    int          stall;
    idle_gap();
    awid    = id;
    awaddr  = base;
    awlen   = len;
    awburst = burst;
    awvalid = 1'b1;
    while (!awready) @(negedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    check_value("wready", wready, 1'b1);
    for (int n = 0; n <= len; n++) begin
      idle_gap();
      wdata  = $urandom;
      wstrb  = $urandom % 16;
      wlast  = (n == len);
      wvalid = 1'b1;
      while (!wready) @(negedge clk);
      addr = beat_addr(base, len, burst, n);
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) begin
          model_data[byte_index(addr, b)]    = wdata[b*8 +: 8];
          model_written[byte_index(addr, b)] = 1'b1;
        end
      end
      @(negedge clk);
      wvalid = 1'b0;
    end
    stall = $urandom % 4;
    for (int s = 0; s <= stall; s++) begin
      if (s > 0) begin
        @(negedge clk);
      end
      check_value("bvalid", bvalid, 1'b1); // Held while bready is low.
      check_value("bid", bid, id);
      check_value("bresp", bresp, okay_resp);
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
    check_value("bvalid", bvalid, 1'b0);
    check_value("awready", awready, 1'b1);
  endtask

  task automatic do_read(input logic [3:0] id, input logic [15:0] base,
                         input logic [7:0] len, input axi_burst_e burst);
    logic [31:0] exp;
    int          stall;
    idle_gap();
    arid    = id;
    araddr  = base;
    arlen   = len;
    arburst = burst;
    arvalid = 1'b1;
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    for (int n = 0; n <= len; n++) begin
      exp   = expected_word(beat_addr(base, len, burst, n));
      stall = $urandom % 4;
      for (int s = 0; s <= stall; s++) begin
        if (s > 0) begin
          @(negedge clk);
        end
        check_value("rvalid", rvalid, 1'b1);
        check_value("rdata", rdata, exp); // Must not move during a stall.
        check_value("rlast", rlast, (n == len));
        check_value("rid", rid, id);
        check_value("rresp", rresp, okay_resp);
      end
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
    end
    check_value("rvalid", rvalid, 1'b0); // No beat beyond len + 1.
    check_value("arready", arready, 1'b1);
  endtask

  // ==============================
  // Main sequence
  // ==============================

  initial begin
    logic [3:0]  id;
    logic [15:0] base;
    logic [7:0]  len;
    axi_burst_e  burst;
    int          waited;
    void'($urandom(32'ha0d));
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    awburst = FIXED;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    arburst = FIXED;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (int i = 0; i < mem_bytes; i++) begin
      model_written[i] = 1'b0;
    end

    for (int c = 1; c <= 9; c++) begin
      @(negedge clk);
      check_value("awready", awready, 1'b0);
      check_value("arready", arready, 1'b0);
      check_value("wready", wready, 1'b0);
      check_value("bvalid", bvalid, 1'b0);
      check_value("rvalid", rvalid, 1'b0);
    end
    while (reset) @(negedge clk);
    waited = 0;
    while (!(awready && arready) && waited < 2) begin
      @(negedge clk);
      waited++;
    end
    check_true(awready && arready, "address ready not raised within two cycles of reset");

    for (int t = 0; t < num_txns; t++) begin
      id    = $urandom % 16;
      burst = axi_burst_e'($urandom % 3);
      if (burst == WRAP) begin
        len = (8'd2 << ($urandom % 4)) - 8'd1; // 2, 4, 8 or 16 beats.
      end else begin
        len = $urandom % 16;
      end
      base = 16'(($urandom % 256) * 4);
      if ($urandom % 2) begin
        do_write(id, base, len, burst);
      end else begin
        do_read(id, base, len, burst);
      end
    end

    $display("Everything OK");
    $finish;
  end

endmodule

// ==== build.f ====
logic/axi_mem_pkg.sv
logic/axi_burst_addr.sv
logic/axi_mem_write_fsm.sv
logic/axi_mem_read_fsm.sv
logic/axi_mem_array.sv
logic/axi_mem_top.sv
tb/tb_clock_gen.sv
tb/axi_mem_tb.sv
